// ==== rtl/npu_pkg.sv ====
`default_nettype none

package npu_pkg;

    // ==============================
    // Sizes
    // ==============================
    localparam int NUM_ENGINES = 4;
    localparam int DATA_AW     = 12;
    localparam int DATA_DEPTH  = 1 << DATA_AW;
    localparam int PROG_AW     = 6;
    localparam int PROG_DEPTH  = 1 << PROG_AW;

    // Product is scaled down by 2^SCALE_SHIFT before saturation
    localparam int SCALE_SHIFT = 4;

    // ==============================
    // Basic types
    // ==============================
    typedef logic signed [7:0]      data_t;
    typedef logic [DATA_AW-1:0]     data_addr_t;
    typedef logic [PROG_AW-1:0]     prog_addr_t;
    typedef logic [NUM_ENGINES-1:0] engine_sel_t;

    typedef enum logic [3:0] {
        OP_NOP       = 4'd0,
        OP_RELU      = 4'd1,
        OP_ADD_IMM   = 4'd2,
        OP_MUL_SHIFT = 4'd3,
        OP_SYNC      = 4'd4,
        OP_END       = 4'd5
    } opcode_t;

    // ==============================
    // Packed words
    // ==============================
    // Program word, 48 bits, opcode in the top nibble
    typedef struct packed {
        opcode_t            opcode;
        data_addr_t         src;
        data_addr_t         dst;
        logic [DATA_AW-1:0] length;
        data_t              imm;
    } instr_t;

    // One byte write into the data SRAM
    typedef struct packed {
        data_addr_t addr;
        data_t      data;
    } mem_wr_t;

endpackage

`default_nettype wire

// ==== rtl/sram_dp.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_dp #(
    parameter type word_t = logic [7:0],
    parameter int  DEPTH  = 64
) (
    input  wire                     clk,
    input  wire                     rd_en,
    input  wire [$clog2(DEPTH)-1:0] rd_addr,
    input  wire                     wr_en,
    input  wire [$clog2(DEPTH)-1:0] wr_addr,
    input  wire word_t              wr_data,
    output word_t                   rd_data
);

    word_t mem [DEPTH];

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/graph_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module graph_sequencer (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start,
    input  wire npu_pkg::prog_addr_t  prog_len,
    input  wire npu_pkg::instr_t      prog_rd_data,
    input  wire npu_pkg::engine_sel_t cmd_ready,
    output logic                      prog_rd_en,
    output npu_pkg::prog_addr_t       prog_rd_addr,
    output npu_pkg::engine_sel_t      cmd_valid,
    output npu_pkg::instr_t           cmd,
    output logic                      busy,
    output logic                      done,
    output npu_pkg::prog_addr_t       pc
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_DISPATCH,
        S_BARRIER,
        S_FINISH
    } state_t;

    state_t               state;
    npu_pkg::prog_addr_t  len_q;
    npu_pkg::instr_t      instr_q;
    logic                 final_q;
    logic                 is_compute;
    logic                 all_ready;
    npu_pkg::engine_sel_t lowest_ready;

    assign is_compute = instr_q.opcode inside {npu_pkg::OP_RELU, npu_pkg::OP_ADD_IMM,
                                               npu_pkg::OP_MUL_SHIFT};
    assign all_ready  = &cmd_ready;

    // Isolate the lowest set ready bit
    assign lowest_ready = cmd_ready & (~cmd_ready + 1'b1);

    assign prog_rd_en   = (state == S_FETCH) && (pc != len_q);
    assign prog_rd_addr = pc;
    assign cmd_valid    = (state == S_DISPATCH && is_compute) ? lowest_ready : '0;
    assign cmd          = instr_q;
    assign busy         = (state != S_IDLE);
    assign done         = (state == S_FINISH);

    // ==============================
    // Control FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            pc      <= '0;
            len_q   <= '0;
            final_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        pc      <= '0;
                        len_q   <= prog_len;
                        final_q <= 1'b0;
                        state   <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    // Running off the end acts like an END at prog_len
                    if (pc == len_q) begin
                        final_q <= 1'b1;
                        state   <= S_BARRIER;
                    end else begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: state <= S_DISPATCH;
                S_DISPATCH: begin
                    case (instr_q.opcode)
                        npu_pkg::OP_SYNC: state <= S_BARRIER;
                        npu_pkg::OP_END: begin
                            final_q <= 1'b1;
                            state   <= S_BARRIER;
                        end
                        npu_pkg::OP_RELU, npu_pkg::OP_ADD_IMM, npu_pkg::OP_MUL_SHIFT: begin
                            // Handshake completes whenever any engine is ready
                            if (|cmd_ready) begin
                                pc    <= pc + 1'b1;
                                state <= S_FETCH;
                            end
                        end
                        default: begin
                            pc    <= pc + 1'b1;
                            state <= S_FETCH;
                        end
                    endcase
                end
                S_BARRIER: begin
                    if (all_ready) begin
                        if (final_q) begin
                            state <= S_FINISH;
                        end else begin
                            pc    <= pc + 1'b1;
                            state <= S_FETCH;
                        end
                    end
                end
                S_FINISH: state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    // Instruction register, loaded one cycle after the fetch
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            instr_q <= prog_rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/math_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module math_engine (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  cmd_valid,
    input  wire npu_pkg::instr_t cmd,
    input  wire                  rd_ready,
    input  wire npu_pkg::data_t  rd_data,
    input  wire                  wr_ready,
    output logic                 cmd_ready,
    output logic                 rd_valid,
    output npu_pkg::data_addr_t  rd_addr,
    output logic                 wr_valid,
    output npu_pkg::mem_wr_t     wr_req
);

    typedef enum logic [1:0] {
        E_IDLE,
        E_READ,
        E_CAPTURE,
        E_WRITE
    } state_t;

    state_t                      state;
    npu_pkg::instr_t             cmd_q;
    logic [npu_pkg::DATA_AW-1:0] idx;
    npu_pkg::data_t              result_q;

    // Clip to the signed byte range
    function automatic npu_pkg::data_t saturate(input logic signed [15:0] v);
        if (v > 16'sd127) begin
            return 8'sd127;
        end
        if (v < -16'sd128) begin
            return -8'sd128;
        end
        return v[7:0];
    endfunction

    function automatic npu_pkg::data_t transform(input npu_pkg::opcode_t op,
                                                 input npu_pkg::data_t   d,
                                                 input npu_pkg::data_t   imm);
        logic signed [15:0] wide;
        case (op)
            npu_pkg::OP_RELU: begin
                return d[7] ? 8'sd0 : d;
            end
            npu_pkg::OP_ADD_IMM: begin
                wide = d + imm;
                return saturate(wide);
            end
            npu_pkg::OP_MUL_SHIFT: begin
                // Full product, arithmetic shift floors negative values
                wide = d * imm;
                return saturate(wide >>> npu_pkg::SCALE_SHIFT);
            end
            default: begin
                return d;
            end
        endcase
    endfunction

    // ==============================
    // Element loop
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= E_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (cmd_valid) begin
                        idx <= '0;
                        if (cmd.length != '0) begin
                            state <= E_READ;
                        end
                    end
                end
                E_READ: begin
                    if (rd_ready) begin
                        state <= E_CAPTURE;
                    end
                end
                E_CAPTURE: state <= E_WRITE;
                E_WRITE: begin
                    if (wr_ready) begin
                        if (idx == cmd_q.length - 1'b1) begin
                            state <= E_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= E_READ;
                        end
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    // Command and result payload
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q <= cmd;
        end
        if (state == E_CAPTURE) begin
            result_q <= transform(cmd_q.opcode, rd_data, cmd_q.imm);
        end
    end

    assign cmd_ready = (state == E_IDLE);
    assign rd_valid  = (state == E_READ);
    assign rd_addr   = cmd_q.src + idx;
    assign wr_valid  = (state == E_WRITE);

    always_comb begin
        wr_req.addr = cmd_q.dst + idx;
        wr_req.data = result_q;
    end

endmodule

`default_nettype wire

// ==== rtl/sram0_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram0_arbiter (
    input  wire npu_pkg::engine_sel_t rd_valid,
    input  wire npu_pkg::engine_sel_t wr_valid,
    input  wire npu_pkg::data_addr_t  rd_addr [npu_pkg::NUM_ENGINES],
    input  wire npu_pkg::mem_wr_t     wr_req  [npu_pkg::NUM_ENGINES],
    input  wire                       tb_rd_en,
    input  wire npu_pkg::data_addr_t  tb_rd_addr,
    input  wire                       tb_wr_en,
    input  wire npu_pkg::mem_wr_t     tb_wr,
    output npu_pkg::engine_sel_t      rd_ready,
    output npu_pkg::engine_sel_t      wr_ready,
    output logic                      mem_rd_en,
    output npu_pkg::data_addr_t       mem_rd_addr,
    output logic                      mem_wr_en,
    output npu_pkg::mem_wr_t          mem_wr
);

    // Read port; scanning downward leaves the lowest requester as winner
    always_comb begin
        rd_ready    = '0;
        mem_rd_en   = tb_rd_en;
        mem_rd_addr = tb_rd_addr;
        for (int i = npu_pkg::NUM_ENGINES - 1; i >= 0; i--) begin
            if (rd_valid[i]) begin
                rd_ready    = '0;
                rd_ready[i] = 1'b1;
                mem_rd_en   = 1'b1;
                mem_rd_addr = rd_addr[i];
            end
        end
    end

    // Write port, same priority, testbench last
    always_comb begin
        wr_ready  = '0;
        mem_wr_en = tb_wr_en;
        mem_wr    = tb_wr;
        for (int i = npu_pkg::NUM_ENGINES - 1; i >= 0; i--) begin
            if (wr_valid[i]) begin
                wr_ready    = '0;
                wr_ready[i] = 1'b1;
                mem_wr_en   = 1'b1;
                mem_wr      = wr_req[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/npu_graph_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module npu_graph_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start,
    input  wire npu_pkg::prog_addr_t prog_len,
    input  wire                      prog_wr_en,
    input  wire npu_pkg::prog_addr_t prog_wr_addr,
    input  wire npu_pkg::instr_t     prog_wr_data,
    input  wire                      tb_wr_en,
    input  wire npu_pkg::mem_wr_t    tb_wr,
    input  wire                      tb_rd_en,
    input  wire npu_pkg::data_addr_t tb_rd_addr,
    output npu_pkg::data_t           tb_rd_data,
    output logic                     graph_busy,
    output logic                     graph_done,
    output npu_pkg::prog_addr_t      graph_pc
);

    logic                 prog_rd_en;
    npu_pkg::prog_addr_t  prog_rd_addr;
    npu_pkg::instr_t      prog_rd_data;

    npu_pkg::engine_sel_t cmd_valid;
    npu_pkg::engine_sel_t cmd_ready;
    npu_pkg::instr_t      cmd;

    npu_pkg::engine_sel_t eng_rd_valid;
    npu_pkg::engine_sel_t eng_rd_ready;
    npu_pkg::data_addr_t  eng_rd_addr [npu_pkg::NUM_ENGINES];
    npu_pkg::engine_sel_t eng_wr_valid;
    npu_pkg::engine_sel_t eng_wr_ready;
    npu_pkg::mem_wr_t     eng_wr_req  [npu_pkg::NUM_ENGINES];

    logic                 mem_rd_en;
    npu_pkg::data_addr_t  mem_rd_addr;
    logic                 mem_wr_en;
    npu_pkg::mem_wr_t     mem_wr;
    npu_pkg::data_t       mem_rd_data;

    // ==============================
    // Memories
    // ==============================
    sram_dp #(.word_t(npu_pkg::instr_t), .DEPTH(npu_pkg::PROG_DEPTH)) prog_mem_i (
        .clk     (clk),
        .rd_en   (prog_rd_en),
        .rd_addr (prog_rd_addr),
        .wr_en   (prog_wr_en),
        .wr_addr (prog_wr_addr),
        .wr_data (prog_wr_data),
        .rd_data (prog_rd_data)
    );

    sram_dp #(.word_t(npu_pkg::data_t), .DEPTH(npu_pkg::DATA_DEPTH)) data_mem_i (
        .clk     (clk),
        .rd_en   (mem_rd_en),
        .rd_addr (mem_rd_addr),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr.addr),
        .wr_data (mem_wr.data),
        .rd_data (mem_rd_data)
    );

    // Read data is broadcast, only the granted requester captures it
    assign tb_rd_data = mem_rd_data;

    // ==============================
    // Control and engines
    // ==============================
    graph_sequencer seq_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .prog_len     (prog_len),
        .prog_rd_data (prog_rd_data),
        .cmd_ready    (cmd_ready),
        .prog_rd_en   (prog_rd_en),
        .prog_rd_addr (prog_rd_addr),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .busy         (graph_busy),
        .done         (graph_done),
        .pc           (graph_pc)
    );

    for (genvar i = 0; i < npu_pkg::NUM_ENGINES; i++) begin : g_engine
        math_engine engine_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .cmd_valid (cmd_valid[i]),
            .cmd       (cmd),
            .rd_ready  (eng_rd_ready[i]),
            .rd_data   (mem_rd_data),
            .wr_ready  (eng_wr_ready[i]),
            .cmd_ready (cmd_ready[i]),
            .rd_valid  (eng_rd_valid[i]),
            .rd_addr   (eng_rd_addr[i]),
            .wr_valid  (eng_wr_valid[i]),
            .wr_req    (eng_wr_req[i])
        );
    end

    sram0_arbiter arb_i (
        .rd_valid    (eng_rd_valid),
        .wr_valid    (eng_wr_valid),
        .rd_addr     (eng_rd_addr),
        .wr_req      (eng_wr_req),
        .tb_rd_en    (tb_rd_en),
        .tb_rd_addr  (tb_rd_addr),
        .tb_wr_en    (tb_wr_en),
        .tb_wr       (tb_wr),
        .rd_ready    (eng_rd_ready),
        .wr_ready    (eng_wr_ready),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_wr_en   (mem_wr_en),
        .mem_wr      (mem_wr)
    );

endmodule

`default_nettype wire

// ==== testbench/npu_graph_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module npu_graph_tb;

    localparam string PATTERN_FILE = "testbench/npu_graph_patterns.txt";

    logic                clk;
    logic                rst_n;
    logic                start;
    npu_pkg::prog_addr_t prog_len;
    logic                prog_wr_en;
    npu_pkg::prog_addr_t prog_wr_addr;
    npu_pkg::instr_t     prog_wr_data;
    logic                tb_wr_en;
    npu_pkg::mem_wr_t    tb_wr;
    logic                tb_rd_en;
    npu_pkg::data_addr_t tb_rd_addr;
    npu_pkg::data_t      tb_rd_data;
    logic                graph_busy;
    logic                graph_done;
    npu_pkg::prog_addr_t graph_pc;

    int                  cycle_count = 0;
    int                  cycle_limit = 0;
    int                  element_total;
    int                  test_total;
    npu_pkg::prog_addr_t prog_count;
    npu_pkg::prog_addr_t run_len;
    npu_pkg::prog_addr_t halt_pc;
    npu_pkg::data_addr_t exp_addr [$];
    npu_pkg::data_t      exp_byte [$];

    npu_graph_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Limit is known once the pattern file has been scanned
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: graph_done never arrived within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // ==============================
    // Compare tasks
    // ==============================
    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input npu_pkg::data_addr_t addr, input npu_pkg::data_t got,
                              input npu_pkg::data_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: data[%h] is %h, expected %h", $time, addr, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_pc(input npu_pkg::prog_addr_t got, input npu_pkg::prog_addr_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: graph_pc is %0d, expected %0d", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic require_fields(input int got, input int exp);
        if (got != exp) begin
            $display("pattern file record has %0d fields where %0d are needed", got, exp);
            stop_on_error();
        end
    endtask

    // ==============================
    // Port access
    // ==============================
    task automatic write_prog(input npu_pkg::prog_addr_t addr, input npu_pkg::instr_t word);
        @(negedge clk);
        prog_wr_en   = 1'b1;
        prog_wr_addr = addr;
        prog_wr_data = word;
        @(negedge clk);
        prog_wr_en = 1'b0;
    endtask

    task automatic write_byte(input npu_pkg::data_addr_t addr, input npu_pkg::data_t value);
        @(negedge clk);
        tb_wr_en     = 1'b1;
        tb_wr.addr   = addr;
        tb_wr.data   = value;
        @(negedge clk);
        tb_wr_en = 1'b0;
    endtask

    // Read data is taken one falling edge after the request
    task automatic read_byte(input npu_pkg::data_addr_t addr, output npu_pkg::data_t value);
        @(negedge clk);
        tb_rd_en   = 1'b1;
        tb_rd_addr = addr;
        @(negedge clk);
        tb_rd_en = 1'b0;
        value    = tb_rd_data;
    endtask

    task automatic run_test();
        npu_pkg::data_t value;
        @(negedge clk);
        start    = 1'b1;
        prog_len = run_len;
        @(negedge clk);
        start = 1'b0;
        check_flag("graph_busy after start", graph_busy, 1'b1);
        while (graph_done !== 1'b1) begin
            @(negedge clk);
        end
        check_pc(graph_pc, halt_pc);
        @(negedge clk);
        check_flag("graph_busy after graph_done", graph_busy, 1'b0);
        check_flag("graph_done after its pulse", graph_done, 1'b0);
        while (exp_addr.size() > 0) begin
            read_byte(exp_addr[0], value);
            check_data(exp_addr[0], value, exp_byte[0]);
            void'(exp_addr.pop_front());
            void'(exp_byte.pop_front());
        end
        prog_count = '0;
        repeat ($urandom % 4) @(negedge clk);
    endtask

    // ==============================
    // Pattern file
    // ==============================
    // Returns the next record letter past blanks and comment lines
    function automatic int next_record(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == 35) begin
                while (c != -1 && c != 10) begin
                    c = $fgetc(fd);
                end
            end else if (c > 32) begin
                return c;
            end else begin
                c = $fgetc(fd);
            end
        end
        return -1;
    endfunction

    // The first pass only sizes the run and the second one drives it
    task automatic process_file(input bit execute);
        int              fd;
        int              rec;
        int              code;
        int              f0;
        int              f1;
        int              f2;
        int              f3;
        int              f4;
        logic [7:0]      letter;
        npu_pkg::instr_t instr;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open pattern file %s", PATTERN_FILE);
            stop_on_error();
        end
        rec = next_record(fd);
        while (rec != -1) begin
            letter = rec[7:0];
            case (letter)
                "P": begin
                    code = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                    require_fields(code, 5);
                    if (execute) begin
                        instr.opcode = npu_pkg::opcode_t'(f0[3:0]);
                        instr.src    = f1[npu_pkg::DATA_AW-1:0];
                        instr.dst    = f2[npu_pkg::DATA_AW-1:0];
                        instr.length = f3[npu_pkg::DATA_AW-1:0];
                        instr.imm    = f4[7:0];
                        write_prog(prog_count, instr);
                        prog_count = prog_count + 1'b1;
                    end else begin
                        element_total += f3;
                    end
                end
                "D", "E": begin
                    code = $fscanf(fd, "%h %h", f0, f1);
                    require_fields(code, 2);
                    for (int i = 0; i < f1; i++) begin
                        code = $fscanf(fd, "%h", f2);
                        require_fields(code, 1);
                        f3 = f0 + i;
                        if (execute && letter == "D") begin
                            write_byte(f3[npu_pkg::DATA_AW-1:0], f2[7:0]);
                        end else if (execute) begin
                            exp_addr.push_back(f3[npu_pkg::DATA_AW-1:0]);
                            exp_byte.push_back(f2[7:0]);
                        end
                    end
                end
                "L": begin
                    code = $fscanf(fd, "%h %h", f0, f1);
                    require_fields(code, 2);
                    run_len = f0[npu_pkg::PROG_AW-1:0];
                    halt_pc = f1[npu_pkg::PROG_AW-1:0];
                end
                "G": begin
                    if (execute) begin
                        run_test();
                    end else begin
                        test_total++;
                    end
                end
                default: begin
                    $display("unknown record letter %c in pattern file", letter);
                    stop_on_error();
                end
            endcase
            rec = next_record(fd);
        end
        $fclose(fd);
    endtask

    initial begin
        void'($urandom(53));
        rst_n         = 1'b0;
        start         = 1'b0;
        prog_len      = '0;
        prog_wr_en    = 1'b0;
        prog_wr_addr  = '0;
        prog_wr_data  = '0;
        tb_wr_en      = 1'b0;
        tb_wr         = '0;
        tb_rd_en      = 1'b0;
        tb_rd_addr    = '0;
        prog_count    = '0;
        run_len       = '0;
        halt_pc       = '0;
        element_total = 0;
        test_total    = 0;
        process_file(1'b0);
        cycle_limit = 16 * element_total + 100 * test_total;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        process_file(1'b1);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/npu_graph_patterns.txt ====
# P opcode src dst length imm / D or E addr count bytes / L prog_len halt_pc / G run
# All fields are hex, bytes are signed two's complement
# ReLU, neighbours of dst unchanged
P 1 100 200 005 00
P 5 000 000 000 00
D 100 5 80 ff 00 01 7f
D 1ff 7 55 11 11 11 11 11 aa
E 1ff 7 55 00 00 00 01 7f aa
L 02 01
G
# Add immediate, +100 and -100 clipping at both ends
P 2 300 310 005 64
P 2 308 318 005 9c
P 5 000 000 000 00
D 300 5 7f 1b 1c 80 9c
D 308 5 80 e4 e3 00 7f
E 310 5 7f 7f 7f e4 00
E 318 5 80 80 80 9c 1b
L 03 02
G
# Multiply by 24 then shift by 4, floor and saturation
P 3 400 410 007 18
P 5 000 000 000 00
D 400 7 10 ff 01 7f 80 fb 00
E 410 7 18 fe 01 7f 80 f8 00
L 02 01
G
# Four engines in parallel, SYNC, then a chained add of -3
P 1 500 510 004 00
P 2 520 530 004 10
P 3 540 550 004 20
P 1 560 570 004 00
P 4 000 000 000 00
P 2 510 580 004 fd
P 5 000 000 000 00
D 500 4 80 05 f0 20
D 510 4 66 66 66 66
D 520 4 01 70 f0 80
D 540 4 08 f8 40 03
D 560 4 7f 81 00 ff
E 510 4 00 05 00 20
E 530 4 11 7f 00 90
E 550 4 10 f0 7f 06
E 570 4 7f 00 00 00
E 580 4 fd 02 fd 1d
L 07 06
G
# No END, NOP first, zero length ReLU leaves its dst alone
P 0 000 000 000 00
P 1 600 610 000 00
P 2 620 630 002 01
D 600 2 80 81
D 610 2 12 34
D 620 2 7e 7f
E 610 2 12 34
E 630 2 7f 7f
L 03 03
G

// ==== npu_graph_top.f ====
rtl/npu_pkg.sv
rtl/sram_dp.sv
rtl/graph_sequencer.sv
rtl/math_engine.sv
rtl/sram0_arbiter.sv
rtl/npu_graph_top.sv
testbench/npu_graph_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module npu_graph_tb \
    -Mdir obj_dir -o npu_graph_sim -f npu_graph_top.f || exit 1
./obj_dir/npu_graph_sim 2>&1 | tee /dev/stderr \
    | grep -x "Simulation completed successfully" > /dev/null \
    && echo "PASS" || { echo "FAIL"; exit 1; }
